/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = ym_timer_tb
FILELIST  = filelist.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD = 8
) (
    output logic clk
);

    // Starts low, first rising edge after half a period
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

/* dv/ym_timer_asserts.sv */
`default_nettype none

module ym_timer_asserts import ym_pkg::*; (
    input wire clk,
    input wire rst,
    input wire data_wr,
    input wire busy,
    input wire flag_a,
    input wire flag_b,
    input wire irq_n
);

    logic [7:0] since_wr;    // Cycles since the last data write, saturating

    always_ff @(posedge clk) begin
        if (rst) begin
            since_wr <= 8'hff;
        end else if (data_wr) begin
            since_wr <= '0;
        end else if (since_wr != 8'hff) begin
            since_wr <= since_wr + 8'd1;
        end
    end

    irq_follows_flags: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |-> (irq_n == !($past(flag_a) || $past(flag_b))))
        else $error("irq_n does not follow the timer flags");

    reset_state: assert property (@(posedge clk) $fell(rst) |-> (irq_n && !busy))
        else $error("irq_n low or busy high after reset");

    // Busy covers at most BUSY_CYCLES clocks past the last data write
    busy_bounded: assert property (@(posedge clk) disable iff (rst)
        busy |-> (since_wr < 8'(BUSY_CYCLES)))
        else $error("busy held longer than the busy window");

endmodule

bind ym_cpu_port ym_timer_asserts u_asserts (
    .clk     (clk),
    .rst     (rst),
    .data_wr (data_wr),
    .busy    (busy),
    .flag_a  (flag_a),
    .flag_b  (flag_b),
    .irq_n   (irq_n)
);

`default_nettype wire

/* dv/ym_timer_tb.sv */
`default_nettype none

module ym_timer_tb import ym_pkg::*; ();

    localparam int SAMPLE     = PRESCALE * SLOTS;    // Clocks per sample with cen held high
    localparam int B_PERIOD   = SAMPLE * TIMER_B_DIV;
    localparam int SETTLE     = 8;                   // Write to flag and irq_n update
    localparam int BUSY_WAIT  = BUSY_CYCLES + 4;
    localparam int TA_VALUE   = 1020;
    localparam int TB_VALUE   = 254;
    localparam int MODE_REACH = 0;    // Status must appear within the limit
    localparam int MODE_HOLD  = 1;    // Status must hold over the limit
    localparam int MODE_BUSY  = 2;    // Busy pulse after the last data write

    logic       clk;
    logic       rst;
    logic       cen;
    logic [7:0] din;
    logic [1:0] addr;
    logic       cs_n;
    logic       wr_n;
    logic [7:0] dout;
    logic       irq_n;

    // Test table, one entry per test, writes kept in a shared list
    string      t_name[$];
    int         t_mode[$];
    int         t_limit[$];
    logic [7:0] t_mask[$];
    logic [7:0] t_dout[$];
    logic       t_irq[$];
    int         t_first[$];
    int         t_count[$];
    reg_addr_t  w_reg[$];
    logic [7:0] w_data[$];
    logic       w_addr_only[$];
    int         next_first;
    int         err_count;
    int         pass_count;
    int         fail_count;

    tb_clock_gen #(.PERIOD(8)) u_clock_gen (.clk(clk));

    ym_timer_top ym_timer_top_inst (
        .clk   (clk),
        .rst   (rst),
        .cen   (cen),
        .din   (din),
        .addr  (addr),
        .cs_n  (cs_n),
        .wr_n  (wr_n),
        .dout  (dout),
        .irq_n (irq_n)
    );

    // Status byte layout: busy, five zeros, flag B, flag A
    function automatic logic [7:0] status_byte(input logic busy, input logic fb, input logic fa);
        return {busy, 5'b00000, fb, fa};
    endfunction

    function automatic logic [7:0] ctl_byte(input logic ld_a, input logic ld_b,
                                            input logic en_a, input logic en_b,
                                            input logic rs_a, input logic rs_b);
        logic [7:0] v;
        v = 8'h00;
        v[CTL_LOAD_A] = ld_a;
        v[CTL_LOAD_B] = ld_b;
        v[CTL_EN_A]   = en_a;
        v[CTL_EN_B]   = en_b;
        v[CTL_RST_A]  = rs_a;
        v[CTL_RST_B]  = rs_b;
        return v;
    endfunction

    function automatic void add_write(input reg_addr_t r, input logic [7:0] d, input logic a_only);
        w_reg.push_back(r);
        w_data.push_back(d);
        w_addr_only.push_back(a_only);
    endfunction

    // Writes added since the previous entry belong to this one
    function automatic void add_test(input string name, input int mode, input int limit,
                                     input logic [7:0] mask, input logic fa, input logic fb);
        t_name.push_back(name);
        t_mode.push_back(mode);
        t_limit.push_back(limit);
        t_mask.push_back(mask);
        t_dout.push_back(status_byte(1'b0, fb, fa) & mask);
        t_irq.push_back(~(fa | fb));    // Low while any flag is set
        t_first.push_back(next_first);
        t_count.push_back(w_reg.size() - next_first);
        next_first = w_reg.size();
    endfunction

    function automatic logic status_ok(input int idx);
        return ((dout & t_mask[idx]) == t_dout[idx]) && (irq_n == t_irq[idx]);
    endfunction

    function automatic void report_mismatch(input int idx);
        $display("Mismatch in %s: expected dout=%02h irq_n=%0b, actual dout=%02h irq_n=%0b",
                 t_name[idx], t_dout[idx], t_irq[idx], dout & t_mask[idx], irq_n);
        err_count++;
    endfunction

    task automatic bus_write(input logic [1:0] a, input logic [7:0] d);
        @(posedge clk);
        #1;
        addr = a;
        din  = d;
        cs_n = 1'b0;
        wr_n = 1'b0;
        @(posedge clk);
        #1;
        cs_n = 1'b1;
        wr_n = 1'b1;
    endtask

    task automatic wait_busy_clear(input string name);
        int n;
        n = 0;
        @(negedge clk);
        while (dout[7] && n < BUSY_WAIT) begin
            @(negedge clk);
            n++;
        end
        assert (!dout[7]) else begin
            $display("Timeout in %s: busy did not clear within %0d cycles", name, BUSY_WAIT);
            err_count++;
        end
    endtask

    task automatic write_reg(input string name, input reg_addr_t r, input logic [7:0] d,
                             input logic a_only);
        bus_write(2'b00, r);       // Register number
        if (!a_only) begin
            wait_busy_clear(name);
            bus_write(2'b01, d);   // Data
        end
    endtask

    task automatic wait_status(input int idx, input int limit, output logic reached);
        int n;
        n = 0;
        @(negedge clk);
        while (!status_ok(idx) && n < limit) begin
            @(negedge clk);
            n++;
        end
        reached = status_ok(idx);
        assert (reached) else begin
            $display("Timeout in %s: status not reached within %0d cycles", t_name[idx], limit);
            report_mismatch(idx);
        end
    endtask

    task automatic hold_status(input int idx);
        int   n;
        logic ok;
        wait_status(idx, SETTLE, ok);
        n = 0;
        while (ok && n < t_limit[idx]) begin
            @(negedge clk);
            ok = status_ok(idx);
            assert (ok) else report_mismatch(idx);
            n++;
        end
    endtask

    task automatic check_busy(input int idx);
        int n;
        @(negedge clk);
        assert (dout[7]) else begin
            $display("Mismatch in %s: expected busy=1, actual busy=%0b", t_name[idx], dout[7]);
            err_count++;
        end
        n = 0;
        while (dout[7] && n < t_limit[idx]) begin
            @(negedge clk);
            n++;
        end
        assert (!dout[7]) else begin
            $display("Timeout in %s: busy still high after %0d cycles", t_name[idx], n);
            err_count++;
        end
        assert (status_ok(idx)) else report_mismatch(idx);
    endtask

    task automatic run_test(input int idx);
        int   i;
        int   errs_before;
        logic reached;
        errs_before = err_count;
        for (i = t_first[idx]; i < t_first[idx] + t_count[idx]; i++) begin
            write_reg(t_name[idx], w_reg[i], w_data[i], w_addr_only[i]);
        end
        case (t_mode[idx])
            MODE_REACH: wait_status(idx, t_limit[idx], reached);
            MODE_HOLD:  hold_status(idx);
            default:    check_busy(idx);
        endcase
        if (err_count == errs_before) begin
            $display("Test %0d %s: ok", idx, t_name[idx]);
            pass_count++;
        end else begin
            $display("Test %0d %s: FAILED", idx, t_name[idx]);
            fail_count++;
        end
    endtask

    task automatic build_table();
        add_test("reset_state", MODE_HOLD, 4, 8'hff, 1'b0, 1'b0);
        add_write(REG_TIMER_B, 8'h00, 1'b0);
        add_test("busy_pulse", MODE_BUSY, BUSY_CYCLES + 2, 8'hff, 1'b0, 1'b0);
        add_write(REG_TIMER_CTL, 8'h00, 1'b1);    // Address phase only
        add_test("addr_only_no_busy", MODE_HOLD, 4, 8'h80, 1'b0, 1'b0);
        add_write(REG_TIMER_A_HI, 8'(TA_VALUE >> 2), 1'b0);
        add_write(REG_TIMER_A_LO, 8'(TA_VALUE & 3), 1'b0);
        add_write(REG_TIMER_CTL, ctl_byte(1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0), 1'b0);
        add_test("timer_a_quiet", MODE_HOLD, 2 * SAMPLE, 8'h03, 1'b0, 1'b0);
        add_test("timer_a_flag", MODE_REACH, 6 * SAMPLE, 8'h03, 1'b1, 1'b0);
        add_write(REG_TIMER_CTL, ctl_byte(1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0), 1'b0);
        add_test("timer_a_clear", MODE_REACH, SETTLE, 8'h03, 1'b0, 1'b0);
        add_test("timer_a_reload", MODE_REACH, 6 * SAMPLE, 8'h03, 1'b1, 1'b0);
        add_write(REG_TIMER_CTL, ctl_byte(1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1), 1'b0);
        add_test("timer_a_stopped", MODE_HOLD, 6 * SAMPLE, 8'h03, 1'b0, 1'b0);
        add_write(REG_TIMER_B, 8'(TB_VALUE), 1'b0);
        add_write(REG_TIMER_CTL, ctl_byte(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0), 1'b0);
        add_test("timer_b_no_enable", MODE_HOLD, 4 * B_PERIOD, 8'h03, 1'b0, 1'b0);
        add_write(REG_TIMER_CTL, ctl_byte(1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0), 1'b0);
        add_test("timer_b_flag", MODE_REACH, 3 * B_PERIOD, 8'h03, 1'b0, 1'b1);
    endtask

    initial begin
        int idx;
        rst        = 1'b1;
        cen        = 1'b1;
        din        = 8'h00;
        addr       = 2'b00;
        cs_n       = 1'b1;
        wr_n       = 1'b1;
        next_first = 0;
        err_count  = 0;
        pass_count = 0;
        fail_count = 0;
        build_table();
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        for (idx = 0; idx < t_name.size(); idx++) begin
            run_test(idx);
        end
        $display("Tests run: %0d, passed: %0d, failed: %0d",
                 t_name.size(), pass_count, fail_count);
        if (fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
hw/ym_pkg.sv
hw/ym_cpu_port.sv
hw/ym_timer_regs.sv
hw/ym_tick_gen.sv
hw/ym_timer.sv
hw/ym_timer_top.sv
dv/tb_clock_gen.sv
dv/ym_timer_asserts.sv
dv/ym_timer_tb.sv

/* hw/ym_cpu_port.sv */
`default_nettype none

module ym_cpu_port import ym_pkg::*; (
    input  wire             clk,
    input  wire             rst,
    input  wire [7:0]       din,
    input  wire [1:0]       addr,    // addr[1] selects the second bank, not kept here
    input  wire             cs_n,
    input  wire             wr_n,
    input  wire             flag_a,
    input  wire             flag_b,
    output logic            reg_we,
    output reg_addr_t       reg_num,
    output logic [7:0]      reg_data,
    output logic [7:0]      dout,
    output logic            irq_n
);

    logic              write;
    logic              data_wr;
    logic [BUSY_W-1:0] busy_cnt;
    logic              busy;

    assign write   = ~cs_n & ~wr_n;
    assign data_wr = write & addr[0];  // Odd address carries data

    // Register number latch and write strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            reg_num <= '0;
            reg_we  <= 1'b0;
        end else begin
            reg_we <= data_wr;    // One cycle after the bus write
            if (write && !addr[0]) begin
                reg_num <= din;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (data_wr) begin
            reg_data <= din;
        end
    end

    // Busy window, restarted by every data write
    always_ff @(posedge clk) begin
        if (rst) begin
            busy_cnt <= '0;
        end else if (data_wr) begin
            busy_cnt <= BUSY_W'(BUSY_CYCLES);
        end else if (busy) begin
            busy_cnt <= busy_cnt - 1'b1;
        end
    end

    assign busy = busy_cnt != '0;

    // Interrupt line, active low
    always_ff @(posedge clk) begin
        if (rst) begin
            irq_n <= 1'b1;
        end else begin
            irq_n <= ~(flag_a | flag_b);
        end
    end

    // Status byte, always presented
    assign dout = {busy, 5'b00000, flag_b, flag_a};

endmodule

`default_nettype wire

/* hw/ym_pkg.sv */
`default_nettype none

package ym_pkg;

    typedef logic [7:0] reg_addr_t;
    typedef logic [9:0] timer_a_t;    // Timer A count and value
    typedef logic [7:0] timer_b_t;

    // Timer registers, first bank only
    localparam reg_addr_t REG_TIMER_A_HI = 8'h24;  // Timer A bits [9:2]
    localparam reg_addr_t REG_TIMER_A_LO = 8'h25;  // Timer A bits [1:0]
    localparam reg_addr_t REG_TIMER_B    = 8'h26;
    localparam reg_addr_t REG_TIMER_CTL  = 8'h27;

    // Bit positions in the control register
    localparam int CTL_LOAD_A = 0;
    localparam int CTL_LOAD_B = 1;
    localparam int CTL_EN_A   = 2;
    localparam int CTL_EN_B   = 3;
    localparam int CTL_RST_A  = 4;
    localparam int CTL_RST_B  = 5;

    // Sample rate derivation, 6 x 24 = 144 cen pulses per sample
    localparam int PRESCALE    = 6;
    localparam int SLOTS       = 24;
    localparam int TIMER_B_DIV = 16;  // Sample pulses per timer B tick

    localparam int BUSY_CYCLES = 32;  // Clocks of busy after a data write

    // Counter widths derived from the constants above
    localparam int PRE_W  = $clog2(PRESCALE);
    localparam int SLOT_W = $clog2(SLOTS);
    localparam int DIV_W  = $clog2(TIMER_B_DIV);
    localparam int BUSY_W = $clog2(BUSY_CYCLES + 1);

endpackage

`default_nettype wire

/* hw/ym_tick_gen.sv */
`default_nettype none

module ym_tick_gen import ym_pkg::*; (
    input  wire  clk,
    input  wire  rst,
    input  wire  cen,
    output logic tick_a,
    output logic tick_b
);

    logic [PRE_W-1:0]  pre_cnt;
    logic [SLOT_W-1:0] slot_cnt;
    logic [DIV_W-1:0]  div_cnt;
    logic              pre_last;
    logic              slot_last;

    assign pre_last  = pre_cnt == PRE_W'(PRESCALE - 1);
    assign slot_last = slot_cnt == SLOT_W'(SLOTS - 1);

    // Sample pulse on the last cen of the last slot
    assign tick_a = cen & pre_last & slot_last;
    assign tick_b = tick_a & (div_cnt == DIV_W'(TIMER_B_DIV - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            pre_cnt  <= '0;
            slot_cnt <= '0;
            div_cnt  <= '0;
        end else if (cen) begin
            pre_cnt <= pre_last ? '0 : pre_cnt + 1'b1;
            if (pre_last) begin
                slot_cnt <= slot_last ? '0 : slot_cnt + 1'b1;  // One internal tick
            end
            if (tick_a) begin
                div_cnt <= tick_b ? '0 : div_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/ym_timer.sv */
`default_nettype none

module ym_timer #(
    parameter type count_t = logic [7:0]
) (
    input  wire         clk,
    input  wire         rst,
    input  wire         tick,
    input  wire count_t value,
    input  wire         load,
    input  wire         en,
    input  wire         clr,
    output logic        flag
);

    count_t cnt;
    logic   load_d;
    logic   load_rise;
    logic   at_max;
    logic   overflow;

    assign load_rise = load & ~load_d;
    assign at_max    = &cnt;

    // Counter start has priority over a tick in the same cycle
    assign overflow = tick & load & ~load_rise & at_max;

    always_ff @(posedge clk) begin
        if (rst) begin
            load_d <= 1'b0;
        end else begin
            load_d <= load;
        end
    end

    // Up counter, stopped while load is low
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (load_rise) begin
            cnt <= value;
        end else if (load && tick) begin
            cnt <= at_max ? value : cnt + 1'b1;  // Reload on overflow
        end
    end

    // Setting wins over a clear in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            flag <= 1'b0;
        end else if (overflow && en) begin
            flag <= 1'b1;
        end else if (clr) begin
            flag <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hw/ym_timer_regs.sv */
`default_nettype none

module ym_timer_regs import ym_pkg::*; (
    input  wire             clk,
    input  wire             rst,
    input  wire             reg_we,
    input  wire reg_addr_t  reg_num,
    input  wire [7:0]       reg_data,
    output timer_a_t        value_a,
    output timer_b_t        value_b,
    output logic            load_a,
    output logic            load_b,
    output logic            en_a,
    output logic            en_b,
    output logic            clr_a,
    output logic            clr_b
);

    logic [7:0] a_hi;
    logic [1:0] a_lo;
    logic       ctl_wr;

    assign ctl_wr = reg_we && (reg_num == REG_TIMER_CTL);

    // Timer reload values
    always_ff @(posedge clk) begin
        if (reg_we) begin
            case (reg_num)
                REG_TIMER_A_HI: a_hi    <= reg_data;
                REG_TIMER_A_LO: a_lo    <= reg_data[1:0];
                REG_TIMER_B:    value_b <= reg_data;
                default: ;
            endcase
        end
    end

    // Ten bit timer A value from both halves
    assign value_a = {a_hi, a_lo};

    // Control levels hold until the next control write
    always_ff @(posedge clk) begin
        if (rst) begin
            load_a <= 1'b0;
            load_b <= 1'b0;
            en_a   <= 1'b0;
            en_b   <= 1'b0;
        end else if (ctl_wr) begin
            load_a <= reg_data[CTL_LOAD_A];
            load_b <= reg_data[CTL_LOAD_B];
            en_a   <= reg_data[CTL_EN_A];
            en_b   <= reg_data[CTL_EN_B];
        end
    end

    // Flag clears are single cycle strobes
    always_ff @(posedge clk) begin
        if (rst) begin
            clr_a <= 1'b0;
            clr_b <= 1'b0;
        end else begin
            clr_a <= ctl_wr & reg_data[CTL_RST_A];
            clr_b <= ctl_wr & reg_data[CTL_RST_B];
        end
    end

endmodule

`default_nettype wire

/* hw/ym_timer_top.sv */
`default_nettype none

module ym_timer_top import ym_pkg::*; (
    input  wire        clk,
    input  wire        rst,
    input  wire        cen,     // Clock enable, sets the sample rate
    input  wire  [7:0] din,
    input  wire  [1:0] addr,
    input  wire        cs_n,
    input  wire        wr_n,
    output logic [7:0] dout,
    output logic       irq_n
);

    logic       reg_we;
    reg_addr_t  reg_num;
    logic [7:0] reg_data;

    timer_a_t   value_a;
    timer_b_t   value_b;
    logic       load_a;
    logic       load_b;
    logic       en_a;
    logic       en_b;
    logic       clr_a;
    logic       clr_b;

    logic       tick_a;
    logic       tick_b;
    logic       flag_a;
    logic       flag_b;

    ym_cpu_port u_cpu_port (
        .clk      (clk),
        .rst      (rst),
        .din      (din),
        .addr     (addr),
        .cs_n     (cs_n),
        .wr_n     (wr_n),
        .flag_a   (flag_a),
        .flag_b   (flag_b),
        .reg_we   (reg_we),
        .reg_num  (reg_num),
        .reg_data (reg_data),
        .dout     (dout),
        .irq_n    (irq_n)
    );

    ym_timer_regs u_timer_regs (
        .clk      (clk),
        .rst      (rst),
        .reg_we   (reg_we),
        .reg_num  (reg_num),
        .reg_data (reg_data),
        .value_a  (value_a),
        .value_b  (value_b),
        .load_a   (load_a),
        .load_b   (load_b),
        .en_a     (en_a),
        .en_b     (en_b),
        .clr_a    (clr_a),
        .clr_b    (clr_b)
    );

    ym_tick_gen u_tick_gen (
        .clk    (clk),
        .rst    (rst),
        .cen    (cen),
        .tick_a (tick_a),
        .tick_b (tick_b)
    );

    // Timer A ticks once per sample
    ym_timer #(.count_t(timer_a_t)) u_timer_a (
        .clk   (clk),
        .rst   (rst),
        .tick  (tick_a),
        .value (value_a),
        .load  (load_a),
        .en    (en_a),
        .clr   (clr_a),
        .flag  (flag_a)
    );

    ym_timer #(.count_t(timer_b_t)) u_timer_b (
        .clk   (clk),
        .rst   (rst),
        .tick  (tick_b),   // Every 16th sample
        .value (value_b),
        .load  (load_b),
        .en    (en_b),
        .clr   (clr_b),
        .flag  (flag_b)
    );

endmodule

`default_nettype wire
